// ==== rtl/spi_flash_params.svh ====
`ifndef SPI_FLASH_PARAMS_SVH
`define SPI_FLASH_PARAMS_SVH

// ********************
// buffer geometry
// ********************

// host side word width, both buffers
`define SPI_WORD_BITS 32

// words per buffer
`define SPI_BUF_WORDS 128

// bit position within a transfer, 128 words x 32 bits = 4096 bits
`define SPI_BIT_IDX_BITS 12

// transfer length in bytes, 0 stands for the full 512 bytes
`define SPI_BYTE_CNT_BITS 9

`endif

// ==== rtl/spi_flash_pkg.sv ====
`include "spi_flash_params.svh"

package spi_flash_pkg;

    // width of the bit-within-word select
    localparam int unsigned WSEL_BITS = $clog2(`SPI_WORD_BITS);

    typedef logic [`SPI_WORD_BITS-1:0]         word_t;      // one buffer word
    typedef logic [$clog2(`SPI_BUF_WORDS)-1:0] word_addr_t; // word address, either buffer
    typedef logic [`SPI_BIT_IDX_BITS-1:0]      bit_idx_t;   // bit position in a transfer
    typedef logic [`SPI_BYTE_CNT_BITS-1:0]     byte_cnt_t;  // transfer length in bytes
    typedef logic [WSEL_BITS-1:0]              bit_sel_t;   // bit number inside a word

    // transfer sequencing
    typedef enum logic [1:0] {IDLE, SHIFT, DONE} xfer_state_t;

    // upper index bits pick the word
    function automatic word_addr_t idx_word(bit_idx_t idx);
        return word_addr_t'(idx >> WSEL_BITS);
    endfunction

    // low index bits count down from the MSB, so bit 0 of a transfer is word bit 31
    function automatic bit_sel_t idx_bit(bit_idx_t idx);
        return bit_sel_t'((`SPI_WORD_BITS - 1) - idx[WSEL_BITS-1:0]);
    endfunction

endpackage

// ==== rtl/spi_bit_counter.sv ====
`timescale 1ns/1ps

module spi_bit_counter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,     // qualified strobe, idle only
    input  spi_flash_pkg::byte_cnt_t byte_cnt, // sampled with start
    input  logic                    cnt_clear,
    input  logic                    cnt_en,
    output spi_flash_pkg::bit_idx_t bit_idx,   // current bit of the transfer
    output logic                    last_bit   // count sits on the final bit
);
    import spi_flash_pkg::*;

    bit_idx_t last_idx; // 8 x len - 1, captured at start

    // ********************
    // length capture
    // ********************
    // a byte count of 0 wraps to 4095, i.e. the whole 512-byte buffer
    always_ff @(posedge clk)
    begin
        if (reset)
            last_idx <= '0;
        else if (start)
            last_idx <= {byte_cnt, 3'b000} - bit_idx_t'(1); // bytes to bits, minus one
    end

    // ********************
    // bit counter
    // ********************
    always_ff @(posedge clk)
    begin
        if (reset)
            bit_idx <= '0;
        else if (cnt_clear)
            bit_idx <= '0;                         // ready for the next transfer
        else if (cnt_en)
            bit_idx <= bit_idx + bit_idx_t'(1);    // one bit per shift cycle
    end

    // single compare point for end of transfer
    assign last_bit = (bit_idx == last_idx);

endmodule

// ==== rtl/spi_xfer_fsm.sv ====
`timescale 1ns/1ps

module spi_xfer_fsm (
    input  logic clk,
    input  logic reset,
    input  logic cmd_strobe, // one-cycle host command
    input  logic last_bit,   // from the bit counter
    output logic start,      // strobe accepted, latch length
    output logic cnt_clear,
    output logic cnt_en,
    output logic shifting,   // bit write enable for the rx buffer
    output logic spi_ss,     // active low
    output logic spi_clk,
    output logic busy,
    output logic done
);
    import spi_flash_pkg::*;

    xfer_state_t state;
    xfer_state_t state_next;

    // ********************
    // next state
    // ********************
    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (cmd_strobe)
                    state_next = SHIFT;  // go straight to shifting, no load cycle
            end
            SHIFT:
            begin
                if (last_bit)
                    state_next = DONE;   // final bit goes out this cycle
            end
            DONE:
            begin
                state_next = IDLE;       // one cycle only
            end
            default:
            begin
                state_next = IDLE;       // unused encoding
            end
        endcase
    end

    // ********************
    // state and registered outputs
    // ********************
    // ss and done follow the next state so they line up with the state itself
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= IDLE;
            spi_ss <= 1'b1;  // deselected
            done   <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            spi_ss <= (state_next != SHIFT);
            done   <= (state_next == DONE);
        end
    end

    // counter and buffer controls
    assign start     = (state == IDLE) && cmd_strobe; // strobes while busy are dropped
    assign cnt_en    = (state == SHIFT);
    assign shifting  = (state == SHIFT);             // miso written on the edge ending each bit
    assign cnt_clear = (state == DONE);              // counter back to 0 for next command

    // busy covers shifting plus the done cycle
    assign busy = (state != IDLE);

    // flash clock is the inverted system clock, only while selected
    // spi_ss moves on the rising clk edge, when ~clk is already low
    assign spi_clk = ~clk & ~spi_ss;

endmodule

// ==== rtl/spi_tx_buffer.sv ====
`timescale 1ns/1ps

`include "spi_flash_params.svh"

module spi_tx_buffer (
    input  logic                      clk,
    input  logic                      wr_en,    // host word write
    input  spi_flash_pkg::word_addr_t wr_addr,
    input  spi_flash_pkg::word_t      wr_data,
    input  spi_flash_pkg::bit_idx_t   bit_idx,  // transfer bit being sent
    output logic                      mosi
);
    import spi_flash_pkg::*;

    // ********************
    // storage
    // ********************
    word_t mem [`SPI_BUF_WORDS]; // 128 x 32, plain array, no reset

    word_addr_t rd_word; // word holding the current bit
    bit_sel_t   rd_bit;  // position within it, MSB first
    word_t      rd_data; // selected word

    // 32-bit host port, whole words only
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // ********************
    // 1-bit read port
    // ********************
    // bit_idx is a register, so mosi settles just after the rising edge
    // and is stable when the device samples on the rising spi_clk
    always_comb
    begin
        rd_word = idx_word(bit_idx);
        rd_bit  = idx_bit(bit_idx);
    end

    assign rd_data = mem[rd_word];
    assign mosi    = rd_data[rd_bit];

endmodule

// ==== rtl/spi_rx_buffer.sv ====
`timescale 1ns/1ps

`include "spi_flash_params.svh"

module spi_rx_buffer (
    input  logic                      clk,
    input  logic                      bit_wr_en, // high during each shift cycle
    input  spi_flash_pkg::bit_idx_t   bit_idx,   // transfer bit being captured
    input  logic                      miso,
    input  logic                      rd_en,     // host word read
    input  spi_flash_pkg::word_addr_t rd_addr,
    output spi_flash_pkg::word_t      rd_data    // valid the cycle after rd_en
);
    import spi_flash_pkg::*;

    // ********************
    // storage
    // ********************
    word_t mem [`SPI_BUF_WORDS]; // 128 x 32, no reset like a RAM

    word_addr_t wr_word; // target word for the incoming bit
    bit_sel_t   wr_bit;  // target bit, MSB first

    always_comb
    begin
        wr_word = idx_word(bit_idx);
        wr_bit  = idx_bit(bit_idx);
    end

    // ********************
    // 1-bit write port
    // ********************
    // miso sampled on the rising clk edge that ends shift cycle k, into bit k
    always_ff @(posedge clk)
    begin
        if (bit_wr_en)
            mem[wr_word][wr_bit] <= miso; // other bits of the word untouched
    end

    // ********************
    // 32-bit read port
    // ********************
    // registered, holds last word when not enabled
    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

endmodule

// ==== rtl/spi_flash_ctrl.sv ====
`timescale 1ns/1ps

module spi_flash_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    // command
    input  logic                       cmd_strobe,    // one-cycle pulse
    input  spi_flash_pkg::byte_cnt_t   byte_cnt,      // sampled with cmd_strobe
    // write buffer, host side
    input  logic                       wbuf_wr_en,
    input  spi_flash_pkg::word_addr_t  wbuf_wr_addr,
    input  spi_flash_pkg::word_t       wbuf_data_in,
    // read buffer, host side
    input  logic                       rbuf_rd_en,
    input  spi_flash_pkg::word_addr_t  rbuf_rd_addr,
    output spi_flash_pkg::word_t       rbuf_data_out,
    // status
    output logic                       busy,
    output logic                       done,          // one pulse per transfer
    // flash pins
    output logic                       spi_clk,
    output logic                       spi_mosi,
    input  logic                       spi_miso,
    output logic                       spi_ss         // active low
);
    import spi_flash_pkg::*;

    // fsm <-> counter
    logic     start;
    logic     cnt_clear;
    logic     cnt_en;
    logic     last_bit;
    bit_idx_t bit_idx;  // shared by both buffers

    logic     shifting; // rx bit write enable

    // ********************
    // control
    // ********************
    spi_xfer_fsm u_fsm (
        .clk        (clk),
        .reset      (reset),
        .cmd_strobe (cmd_strobe),
        .last_bit   (last_bit),
        .start      (start),
        .cnt_clear  (cnt_clear),
        .cnt_en     (cnt_en),
        .shifting   (shifting),
        .spi_ss     (spi_ss),
        .spi_clk    (spi_clk),
        .busy       (busy),
        .done       (done)
    );

    spi_bit_counter u_counter (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .byte_cnt  (byte_cnt),
        .cnt_clear (cnt_clear),
        .cnt_en    (cnt_en),
        .bit_idx   (bit_idx),
        .last_bit  (last_bit)
    );

    // ********************
    // buffers
    // ********************
    spi_tx_buffer u_tx_buf (
        .clk     (clk),
        .wr_en   (wbuf_wr_en),
        .wr_addr (wbuf_wr_addr),
        .wr_data (wbuf_data_in),
        .bit_idx (bit_idx),
        .mosi    (spi_mosi)
    );

    spi_rx_buffer u_rx_buf (
        .clk       (clk),
        .bit_wr_en (shifting),
        .bit_idx   (bit_idx),
        .miso      (spi_miso),
        .rd_en     (rbuf_rd_en),
        .rd_addr   (rbuf_rd_addr),
        .rd_data   (rbuf_data_out)
    );

endmodule

// ==== tests/spi_clock_gen.sv ====
`timescale 1ns/1ps

module spi_clock_gen (
    output logic clk,
    output logic reset
);
    localparam int HALF_PERIOD = 20; // 40 ns clock

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset spans two rising edges, dropped on a falling edge
    initial
    begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== tests/spi_flash_tb.sv ====
`timescale 1ns/1ps

`include "spi_flash_params.svh"

module spi_flash_tb;
    import spi_flash_pkg::*;

    localparam int N_XFERS  = 6;    // transfers in the run
    localparam int MAX_BITS = `SPI_BUF_WORDS * `SPI_WORD_BITS;

    logic       clk;
    logic       reset;
    logic       cmd_strobe;
    byte_cnt_t  byte_cnt;
    logic       wbuf_wr_en;
    word_addr_t wbuf_wr_addr;
    word_t      wbuf_data_in;
    logic       rbuf_rd_en;
    word_addr_t rbuf_rd_addr;
    word_t      rbuf_data_out;
    logic       busy;
    logic       done;
    logic       spi_clk;
    logic       spi_mosi;
    logic       spi_miso;
    logic       spi_ss;

    // reference copies of both buffers
    word_t tx_model [`SPI_BUF_WORDS];
    word_t rx_model [`SPI_BUF_WORDS];

    logic [31:0] lfsr_state = 32'h3b38_e2c9;
    logic [31:0] miso_word;          // responder's draw
    logic        prev_ss_low = 1'b0; // ss level at the previous falling edge
    int          low_cnt;            // shift cycles seen in this transfer
    int          done_count;         // done pulses in this transfer
    int          word_errs  = 0;
    int          bit_errs   = 0;
    int          count_errs = 0;

    spi_clock_gen clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    spi_flash_ctrl UUT (
        .clk           (clk),
        .reset         (reset),
        .cmd_strobe    (cmd_strobe),
        .byte_cnt      (byte_cnt),
        .wbuf_wr_en    (wbuf_wr_en),
        .wbuf_wr_addr  (wbuf_wr_addr),
        .wbuf_data_in  (wbuf_data_in),
        .rbuf_rd_en    (rbuf_rd_en),
        .rbuf_rd_addr  (rbuf_rd_addr),
        .rbuf_data_out (rbuf_data_out),
        .busy          (busy),
        .done          (done),
        .spi_clk       (spi_clk),
        .spi_mosi      (spi_mosi),
        .spi_miso      (spi_miso),
        .spi_ss        (spi_ss)
    );

    // ********************
    // random source
    // ********************
    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit returned
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // ********************
    // compare tasks
    // ********************
    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            word_errs++;
            $display("error %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            bit_errs++;
            $display("error %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_count(input string name, input bit_idx_t exp, input bit_idx_t act);
        if (act !== exp)
        begin
            count_errs++;
            $display("error %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic report_timeout(input xfer_state_t phase, input string what);
        $display("timeout: gave up waiting for %s during %s", what, phase.name());
        $display("errors word %0d bit %0d count %0d", word_errs, bit_errs, count_errs);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // ********************
    // flash side responder and monitor
    // ********************
    // mosi, ss, busy and done move on the rising edge, so they are steady here
    always @(negedge clk)
    begin
        if (!reset)
        begin
            check_bit("done", prev_ss_low && spi_ss, done); // only right after ss rises
            check_bit("busy", !spi_ss || done, busy);
            if (done)
                done_count++;
            if (!spi_ss)
            begin
                // bit k lives in word k/32 counted MSB first
                check_bit("spi_mosi", tx_model[low_cnt / 32][31 - low_cnt % 32], spi_mosi);
                miso_word = rand_bits(1);
                spi_miso  = miso_word[0];  // sampled on the next rising edge
                rx_model[low_cnt / 32][31 - low_cnt % 32] = miso_word[0];
                low_cnt++;
            end
            prev_ss_low = !spi_ss;
        end
    end

    // spi_clk sampled mid phase follows ~clk only while selected
    always @(clk)
    begin
        #10;
        if (!reset)
            check_bit("spi_clk", !clk && !spi_ss, spi_clk);
    end

    // ********************
    // host side tasks
    // ********************
    task automatic wait_reset_release();
        int n;
        n = 0;
        while (reset !== 1'b0 && n < 10)
        begin
            @(negedge clk);
            n++;
        end
        if (reset !== 1'b0)
            report_timeout(IDLE, "reset release");
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!done && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!done)
            report_timeout(SHIFT, "done pulse");
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < 4)
        begin
            @(negedge clk);
            n++;
        end
        if (busy)
            report_timeout(DONE, "busy to drop");
    endtask

    // fresh random contents for every word
    task automatic write_tx_buffer();
        int a;
        for (a = 0; a < `SPI_BUF_WORDS; a++)
        begin
            @(negedge clk);
            wbuf_wr_en   = 1'b1;
            wbuf_wr_addr = word_addr_t'(a);
            wbuf_data_in = word_t'(rand_bits(32));
            tx_model[a]  = wbuf_data_in;
        end
        @(negedge clk);
        wbuf_wr_en = 1'b0;
    endtask

    task automatic run_transfer(input byte_cnt_t len, input bit extra_strobe);
        int exp_bits;
        exp_bits   = (len == 0) ? MAX_BITS : 8 * int'(len); // 0 means whole buffer
        low_cnt    = 0;
        done_count = 0;
        @(negedge clk);
        cmd_strobe = 1'b1;
        byte_cnt   = len;
        @(negedge clk);
        cmd_strobe = 1'b0;
        byte_cnt   = byte_cnt_t'(rand_bits(9)); // junk that must not matter now
        check_bit("spi_ss", 1'b0, spi_ss);      // selected one cycle after the strobe
        if (extra_strobe)
        begin
            @(negedge clk);
            cmd_strobe = 1'b1;                  // dropped since busy is high
            byte_cnt   = byte_cnt_t'(rand_bits(9));
            @(negedge clk);
            cmd_strobe = 1'b0;
        end
        wait_done(exp_bits + 10);
        check_count("ss_low_cycles", bit_idx_t'(exp_bits - 1), bit_idx_t'(low_cnt - 1));
        wait_idle();
        check_count("done_pulses", bit_idx_t'(1), bit_idx_t'(done_count));
    endtask

    // data comes back registered one cycle after the enable
    task automatic read_back_rx();
        int a;
        for (a = 0; a < `SPI_BUF_WORDS; a++)
        begin
            @(negedge clk);
            rbuf_rd_en   = 1'b1;
            rbuf_rd_addr = word_addr_t'(a);
            @(negedge clk);
            rbuf_rd_en = 1'b0;
            check_word($sformatf("rbuf_data_out[%0d]", a), rx_model[a], rbuf_data_out);
        end
    endtask

    // ********************
    // main sequence
    // ********************
    initial
    begin
        byte_cnt_t len;
        int        t;
        cmd_strobe   = 1'b0;
        byte_cnt     = '0;
        wbuf_wr_en   = 1'b0;
        wbuf_wr_addr = '0;
        wbuf_data_in = '0;
        rbuf_rd_en   = 1'b0;
        rbuf_rd_addr = '0;
        spi_miso     = 1'b0;

        wait_reset_release();
        @(negedge clk);
        check_bit("spi_ss", 1'b1, spi_ss);   // idle levels out of reset
        check_bit("spi_clk", 1'b0, spi_clk);
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);

        // first one fills the whole rx buffer and later ones overwrite part of it
        for (t = 0; t < N_XFERS; t++)
        begin
            if (t == 0)
                len = '0;
            else if (t == 1)
                len = byte_cnt_t'(1);
            else
                len = byte_cnt_t'(rand_bits(9));
            write_tx_buffer();
            run_transfer(len, t % 2 == 1);  // odd transfers get a stray strobe
            read_back_rx();
        end

        $display("errors word %0d bit %0d count %0d", word_errs, bit_errs, count_errs);
        if (word_errs + bit_errs + count_errs == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/spi_flash_pkg.sv
rtl/spi_bit_counter.sv
rtl/spi_xfer_fsm.sv
rtl/spi_tx_buffer.sv
rtl/spi_rx_buffer.sv
rtl/spi_flash_ctrl.sv
tests/spi_clock_gen.sv
tests/spi_flash_tb.sv
